// File: design/vp_cart_mapper.sv
// Download byte counter and ROM port steering: cart/XROM/font writes and bank-switched cart reads
`timescale 1ns/1ps
`default_nettype none

module vp_cart_mapper (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  vp_glue_pkg::ioctl_t     ioctl_i,
	input  vp_glue_pkg::cart_bus_t  cart_i,
	input  wire [8:0]               char_addr_i,
	input  wire                     char_en_i,
	output vp_glue_pkg::rom_port_t  rom_o,
	output vp_glue_pkg::font_port_t font_o
);
	import vp_glue_pkg::*;

	logic        old_download;
	logic [15:0] cart_size; // Bytes in the last image
	logic        xrom;
	logic        dl_rom;
	logic        dl_font;
	logic [13:0] map_addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_download <= 1'b0;
			cart_size    <= 16'd0;
			xrom         <= 1'b0;
		end else begin
			old_download <= ioctl_i.download;
			if (!old_download && ioctl_i.download) begin // Transfer starts
				cart_size <= 16'd0;
				xrom      <= (ioctl_i.index[1:0] == IDX_XROM);
			end else if (ioctl_i.download && ioctl_i.wr)
				cart_size <= cart_size + 16'd1;
		end
	end

	assign dl_rom  = ioctl_i.download &&
		(ioctl_i.index[1:0] == IDX_CART || ioctl_i.index[1:0] == IDX_XROM);
	assign dl_font = ioctl_i.download && (ioctl_i.index[1:0] == IDX_FONT);

	////////////////////////////////////////////////////////////
	// Cart bus to ROM store address
	always_comb begin
		if (xrom)
			map_addr = {2'b00, cart_i.addr};
		else begin
			case (cart_size)
				CART_4K:  map_addr = {2'b00, cart_i.bank0, cart_i.addr[11], cart_i.addr[9:0]};
				CART_8K:  map_addr = {1'b0, cart_i.bank1, cart_i.bank0, cart_i.addr[11],
					cart_i.addr[9:0]};
				CART_12K: map_addr = {cart_i.bank1, cart_i.bank0, cart_i.addr};
				default:  map_addr = {3'b000, cart_i.addr[11], cart_i.addr[9:0]}; // 2K
			endcase
		end
	end

	assign rom_o.addr = dl_rom ? ioctl_i.addr[13:0] : map_addr;
	assign rom_o.data = ioctl_i.data;
	assign rom_o.wren = ioctl_i.wr && dl_rom;
	assign rom_o.rden = xrom ? (~(cart_i.cs_n & cart_i.bank0) & cart_i.rd_n) : ~cart_i.rd_n;

	assign font_o.addr = dl_font ? ioctl_i.addr[8:0] : char_addr_i;
	assign font_o.data = ioctl_i.data;
	assign font_o.wren = ioctl_i.wr && dl_font;
	assign font_o.rden = char_en_i;

endmodule

`default_nettype wire

// File: design/vp_clock_enables.sv
// CPU and VDC clock-enable pulse generator, one pulse per divider period of the selected TV standard
`timescale 1ns/1ps
`default_nettype none

module vp_clock_enables (
	input  wire  clk_sys,
	input  wire  reset,
	input  wire  pal_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);
	import vp_glue_pkg::*;

	logic [3:0] cpu_ctr;
	logic [3:0] vdc_ctr;
	logic [3:0] cpu_last;
	logic [3:0] vdc_last;
	logic       pal_q; // Standard seen last cycle

	// Counter value on which the pulse is issued
	assign cpu_last = pal_i ? CPU_DIV_PAL - 4'd1 : CPU_DIV_NTSC - 4'd1;
	assign vdc_last = pal_i ? VDC_DIV_PAL - 4'd1 : VDC_DIV_NTSC - 4'd1;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_ctr  <= 4'd0;
			vdc_ctr  <= 4'd0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
			pal_q    <= 1'b0;
		end else begin
			pal_q <= pal_i;
			if (pal_q != pal_i) begin // Standard switched, start over
				cpu_ctr  <= 4'd0;
				vdc_ctr  <= 4'd0;
				cpu_en_o <= 1'b0;
				vdc_en_o <= 1'b0;
			end else begin
				cpu_en_o <= (cpu_ctr >= cpu_last);
				cpu_ctr  <= (cpu_ctr >= cpu_last) ? 4'd0 : cpu_ctr + 4'd1;
				vdc_en_o <= (vdc_ctr >= vdc_last);
				vdc_ctr  <= (vdc_ctr >= vdc_last) ? 4'd0 : vdc_ctr + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: design/vp_glue.sv
// Top of the console glue: clock enables, key encoder, cart mapper and video colour unit
`timescale 1ns/1ps
`default_nettype none

module vp_glue (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     pal_i,
	input  wire [2:0]               contrast_i,
	input  vp_glue_pkg::ps2_key_t   ps2_key_i,
	input  wire [9:0]               joy_num_i,  // Both pads ORed
	input  vp_glue_pkg::ioctl_t     ioctl_i,
	input  vp_glue_pkg::cart_bus_t  cart_i,
	input  wire [8:0]               char_addr_i,
	input  wire                     char_en_i,
	input  wire [3:0]               pix_code_i, // {R, G, B, luma} from the VDC
	output logic                    cpu_en_o,
	output logic                    vdc_en_o,
	output vp_glue_pkg::key_event_t key_o,
	output vp_glue_pkg::rom_port_t  rom_o,
	output vp_glue_pkg::font_port_t font_o,
	output vp_glue_pkg::video_out_t video_o
);

	////////////////////////////////////////////////////////////
	// Clocks
	vp_clock_enables u_clocks (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.pal_i    (pal_i),
		.cpu_en_o (cpu_en_o),
		.vdc_en_o (vdc_en_o)
	);

	////////////////////////////////////////////////////////////
	// Input
	vp_key_encoder u_keys (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.ps2_key_i (ps2_key_i),
		.joy_num_i (joy_num_i),
		.key_o     (key_o)
	);

	////////////////////////////////////////////////////////////
	// Memory
	vp_cart_mapper u_mapper (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl_i     (ioctl_i),
		.cart_i      (cart_i),
		.char_addr_i (char_addr_i),
		.char_en_i   (char_en_i),
		.rom_o       (rom_o),
		.font_o      (font_o)
	);

	////////////////////////////////////////////////////////////
	// Video
	vp_video_color u_video (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.vdc_en_i   (vdc_en_o), // Pixel clock enable
		.pix_code_i (pix_code_i),
		.contrast_i (contrast_i),
		.video_o    (video_o)
	);

endmodule

`default_nettype wire

// File: design/vp_glue_pkg.sv
// Types, divider and size constants and the VDC palette shared by all glue units
`default_nettype none

package vp_glue_pkg;

	// Clock periods between enable pulses
	localparam logic [3:0] CPU_DIV_NTSC = 4'd8;
	localparam logic [3:0] CPU_DIV_PAL  = 4'd12;
	localparam logic [3:0] VDC_DIV_NTSC = 4'd6;
	localparam logic [3:0] VDC_DIV_PAL  = 4'd10;

	// Downloaded byte counts that pick the cart mapping
	localparam logic [15:0] CART_4K  = 16'h1000;
	localparam logic [15:0] CART_8K  = 16'h2000;
	localparam logic [15:0] CART_12K = 16'h4000; // 16K image with 12K banked

	// Low field of the download index
	localparam logic [1:0] IDX_CART = 2'd1;
	localparam logic [1:0] IDX_XROM = 2'd2;
	localparam logic [1:0] IDX_FONT = 2'd3;

	typedef struct packed {
		logic       toggle;   // Flips on every key event
		logic       pressed;
		logic       extended; // E0 prefix
		logic [7:0] code;
	} ps2_key_t;

	typedef struct packed {
		logic       valid;
		logic       released;
		logic [7:0] ascii;
	} key_event_t;

	typedef struct packed {
		logic        download; // High for the whole transfer
		logic        wr;       // One cycle per byte
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_t;

	typedef struct packed {
		logic [11:0] addr;
		logic        bank0;
		logic        bank1;
		logic        rd_n;
		logic        cs_n;
	} cart_bus_t;

	typedef struct packed {
		logic [13:0] addr;
		logic [7:0]  data;
		logic        wren;
		logic        rden;
	} rom_port_t;

	typedef struct packed {
		logic [8:0] addr;
		logic [7:0] data;
		logic       wren;
		logic       rden;
	} font_port_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	typedef struct packed {
		logic [5:0] r;
		logic [5:0] g;
		logic [5:0] b;
		logic [7:0] grey;
	} video_out_t;

	////////////////////////////////////////////////////////////
	// Calibrated VDC colours, indexed by {R, G, B, luma}
	localparam rgb_t PALETTE [16] = '{
		24'h000000, 24'h676767, // black, grey
		24'h1a37be, 24'h5c80f6, // blue
		24'h006d07, 24'h56c469, // green
		24'h2aaabe, 24'h77e6eb, // blue-green
		24'h790000, 24'hc75151, // red
		24'h94309f, 24'hdc84e8, // violet
		24'h77670b, 24'hc6b86a, // khaki
		24'hcecece, 24'hffffff  // light grey, white
	};

endpackage

`default_nettype wire

// File: design/vp_key_encoder.sv
// Converts PS/2 key events and gamepad number keys into one-cycle ASCII key events for the keymap
`timescale 1ns/1ps
`default_nettype none

module vp_key_encoder (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  vp_glue_pkg::ps2_key_t   ps2_key_i,
	input  wire [9:0]               joy_num_i,
	output vp_glue_pkg::key_event_t key_o
);
	import vp_glue_pkg::*;

	logic       old_toggle;
	logic [9:0] old_joy;
	logic       ps2_changed;
	logic       joy_changed;
	logic       ps2_released;
	logic       joy_released;
	logic [7:0] ps2_ascii;
	logic [7:0] joy_ascii;
	logic [7:0] ps2_code;
	logic [7:0] joy_code;
	logic       ps2_edge;

	assign ps2_edge = (old_toggle != ps2_key_i.toggle);

	////////////////////////////////////////////////////////////
	// Scan code table, extended bit ignored
	always_comb begin
		case (ps2_key_i.code)
			8'h16:   ps2_code = "1";
			8'h1E:   ps2_code = "2";
			8'h26:   ps2_code = "3";
			8'h25:   ps2_code = "4";
			8'h2E:   ps2_code = "5";
			8'h36:   ps2_code = "6";
			8'h3D:   ps2_code = "7";
			8'h3E:   ps2_code = "8";
			8'h46:   ps2_code = "9";
			8'h45:   ps2_code = "0";
			8'h1C:   ps2_code = "a";
			8'h32:   ps2_code = "b";
			8'h21:   ps2_code = "c";
			8'h23:   ps2_code = "d";
			8'h24:   ps2_code = "e";
			8'h2B:   ps2_code = "f";
			8'h34:   ps2_code = "g";
			8'h33:   ps2_code = "h";
			8'h43:   ps2_code = "i";
			8'h3B:   ps2_code = "j";
			8'h42:   ps2_code = "k";
			8'h4B:   ps2_code = "l";
			8'h3A:   ps2_code = "m";
			8'h31:   ps2_code = "n";
			8'h44:   ps2_code = "o";
			8'h4D:   ps2_code = "p";
			8'h15:   ps2_code = "q";
			8'h2D:   ps2_code = "r";
			8'h1B:   ps2_code = "s";
			8'h2C:   ps2_code = "t";
			8'h3C:   ps2_code = "u";
			8'h2A:   ps2_code = "v";
			8'h1D:   ps2_code = "w";
			8'h22:   ps2_code = "x";
			8'h35:   ps2_code = "y";
			8'h1A:   ps2_code = "z";
			8'h29:   ps2_code = " ";
			8'h79:   ps2_code = "+"; // Keypad
			8'h7B:   ps2_code = "-";
			8'h7C:   ps2_code = "*";
			8'h4A:   ps2_code = "/";
			8'h55:   ps2_code = "=";
			8'h1F:   ps2_code = 8'h11; // Left GUI, yes
			8'h27:   ps2_code = 8'h12; // Right GUI, no
			8'h5A:   ps2_code = 8'h0A; // Enter
			8'h66:   ps2_code = 8'h08; // Backspace
			default: ps2_code = 8'h00;
		endcase
	end

	// Lowest held number key wins, bit 9 is the zero key
	always_comb begin
		joy_code = 8'h00;
		for (int i = 9; i >= 0; i--) begin
			if (joy_num_i[i])
				joy_code = (i == 9) ? "0" : 8'h31 + 8'(i);
		end
	end

	////////////////////////////////////////////////////////////
	// Change detection and held codes
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_toggle   <= 1'b0;
			old_joy      <= 10'd0;
			ps2_changed  <= 1'b0;
			joy_changed  <= 1'b0;
			ps2_released <= 1'b1;
			joy_released <= 1'b1;
			ps2_ascii    <= 8'h00;
			joy_ascii    <= 8'h00;
		end else begin
			old_toggle   <= ps2_key_i.toggle;
			old_joy      <= joy_num_i;
			ps2_changed  <= ps2_edge;
			joy_changed  <= |(joy_num_i ^ old_joy);
			ps2_released <= ~ps2_key_i.pressed;
			joy_released <= ~|joy_num_i;

			if (ps2_edge)
				ps2_ascii <= ps2_code;
			else if (|joy_num_i)
				joy_ascii <= joy_code; // Kept after release
		end
	end

	assign key_o.valid    = ps2_changed | joy_changed;
	assign key_o.released = ps2_released & joy_released;
	assign key_o.ascii    = ps2_changed ? ps2_ascii : joy_ascii;

endmodule

`default_nettype wire

// File: design/vp_video_color.sv
// Pixel code to palette colour, with the G7200 contrast shuffle and greyscale, registered per VDC pixel
`timescale 1ns/1ps
`default_nettype none

module vp_video_color (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     vdc_en_i,
	input  wire [3:0]               pix_code_i,
	input  wire [2:0]               contrast_i,
	output vp_glue_pkg::video_out_t video_o
);
	import vp_glue_pkg::*;

	rgb_t        pal;   // Plain palette colour
	rgb_t        shuf;  // Contrast-shuffled colour
	logic [15:0] grey_sum;
	logic [7:0]  grey;
	logic        mono;

	assign pal  = PALETTE[pix_code_i];
	assign mono = (contrast_i != 3'd0);

	////////////////////////////////////////////////////////////
	// Contrast shuffle, 1-3 red over blue, 5-7 blue over red
	always_comb begin
		case (contrast_i)
			3'd1: begin
				shuf.r = {pal.r[7:1], pal.b[7]};
				shuf.g = {pal.g[7], pal.r[7:1]};
				shuf.b = {pal.r[7:1], pal.b[7]};
			end
			3'd2: begin
				shuf.r = {pal.r[7:2], pal.b[7:6]};
				shuf.g = {pal.g[7:6], pal.r[7:2]};
				shuf.b = {pal.r[7:2], pal.b[7:6]};
			end
			3'd3: begin
				shuf.r = {pal.r[7:4], pal.b[7:4]};
				shuf.g = {pal.g[7:4], pal.r[7:4]};
				shuf.b = {pal.r[7:4], pal.b[7:4]};
			end
			3'd5: begin
				shuf.r = {pal.b[7:4], pal.r[7:4]};
				shuf.g = {pal.g[7:4], pal.b[7:4]};
				shuf.b = {pal.b[7:4], pal.r[7:4]};
			end
			3'd6: begin
				shuf.r = {pal.b[7:2], pal.r[7:6]};
				shuf.g = {pal.g[7:6], pal.b[7:2]};
				shuf.b = {pal.b[7:2], pal.r[7:6]};
			end
			3'd7: begin
				shuf.r = {pal.b[7:1], pal.r[7]};
				shuf.g = {pal.g[7], pal.b[7:1]};
				shuf.b = {pal.b[7:1], pal.r[7]};
			end
			default: shuf = pal; // 0 and 4
		endcase
	end

	// Luma weights 0.30 / 0.59 / 0.11 in 1/256 steps
	assign grey_sum = 16'd77 * shuf.r + 16'd150 * shuf.g + 16'd29 * shuf.b;
	assign grey     = grey_sum[15:8];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset)
			video_o <= '0;
		else if (vdc_en_i) begin
			video_o.r    <= mono ? grey[7:2] : pal.r[7:2];
			video_o.g    <= mono ? grey[7:2] : pal.g[7:2];
			video_o.b    <= mono ? grey[7:2] : pal.b[7:2];
			video_o.grey <= grey;
		end
	end

endmodule

`default_nettype wire

// File: include/vp_glue_checks.svh
// Compare tasks and error counters for the glue testbench; include inside the testbench module
`ifndef VP_GLUE_CHECKS_SVH
`define VP_GLUE_CHECKS_SVH

int unsigned err_key   = 0;
int unsigned err_rom   = 0;
int unsigned err_font  = 0;
int unsigned err_video = 0;
int unsigned err_en    = 0;

task automatic check_key(input vp_glue_pkg::key_event_t got,
		input vp_glue_pkg::key_event_t exp, input string what);
	if (got !== exp) begin
		err_key++;
		$display("MISMATCH %s: got %h exp %h at %0t", what, got, exp, $time);
	end
endtask

task automatic check_rom(input vp_glue_pkg::rom_port_t got,
		input vp_glue_pkg::rom_port_t exp, input string what);
	if (got !== exp) begin
		err_rom++;
		$display("MISMATCH %s: got %h exp %h at %0t", what, got, exp, $time);
	end
endtask

task automatic check_font(input vp_glue_pkg::font_port_t got,
		input vp_glue_pkg::font_port_t exp, input string what);
	if (got !== exp) begin
		err_font++;
		$display("MISMATCH %s: got %h exp %h at %0t", what, got, exp, $time);
	end
endtask

task automatic check_video(input vp_glue_pkg::video_out_t got,
		input vp_glue_pkg::video_out_t exp, input string what);
	if (got !== exp) begin
		err_video++;
		$display("MISMATCH %s: got %h exp %h at %0t", what, got, exp, $time);
	end
endtask

// Single enable bit such as cpu_en or vdc_en
task automatic check_en(input logic got, input logic exp, input string what);
	if (got !== exp) begin
		err_en++;
		$display("MISMATCH %s: got %h exp %h at %0t", what, got, exp, $time);
	end
endtask

`endif

// File: tb/tb_vp_glue.sv
// Directed testbench for the console glue; run it as top with the project file list
`timescale 1ns/1ps
`default_nettype none

module tb_vp_glue;
	import vp_glue_pkg::*;

	localparam int DL_ODD  = 3000; // Falls back to the 2K mapping
	localparam int DL_XROM = 64;
	localparam int DL_FONT = 64;
	// Download bytes dominate the run, the other tests need a few hundred cycles
	localparam int MAX_CYCLES = 2 * (4096 + 8192 + 16384 + DL_ODD + DL_XROM + DL_FONT + 500);

	logic       clk_sys = 1'b0;
	logic       reset;
	logic       pal_i;
	logic [2:0] contrast_i;
	ps2_key_t   ps2_key_i;
	logic [9:0] joy_num_i;
	ioctl_t     ioctl_i;
	cart_bus_t  cart_i;
	logic [8:0] char_addr_i;
	logic       char_en_i;
	logic [3:0] pix_code_i;
	logic       cpu_en_o;
	logic       vdc_en_o;
	key_event_t key_o;
	rom_port_t  rom_o;
	font_port_t font_o;
	video_out_t video_o;

	integer     seed = 32'ha475_325e;
	int         cycles = 0;
	logic [7:0] joy_ascii_exp = 8'h00; // Held gamepad code
	logic       ps2_rel_exp = 1'b1;
	logic       xrom_exp = 1'b0;
	int         size_exp = 0;          // Bytes in the last download

	`include "vp_glue_checks.svh"

	vp_glue dut (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.pal_i       (pal_i),
		.contrast_i  (contrast_i),
		.ps2_key_i   (ps2_key_i),
		.joy_num_i   (joy_num_i),
		.ioctl_i     (ioctl_i),
		.cart_i      (cart_i),
		.char_addr_i (char_addr_i),
		.char_en_i   (char_en_i),
		.pix_code_i  (pix_code_i),
		.cpu_en_o    (cpu_en_o),
		.vdc_en_o    (vdc_en_o),
		.key_o       (key_o),
		.rom_o       (rom_o),
		.font_o      (font_o),
		.video_o     (video_o)
	);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout: run stopped after %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference rules

	// PS/2 set 2 scan code and its ASCII
	function automatic logic [15:0] key_entry(input int i);
		case (i)
			0:       return {8'h16, "1"};
			1:       return {8'h45, "0"};
			2:       return {8'h1C, "a"};
			3:       return {8'h1A, "z"};
			4:       return {8'h29, " "};
			5:       return {8'h79, "+"};
			6:       return {8'h7B, "-"};
			7:       return {8'h7C, "*"};
			8:       return {8'h4A, "/"};
			9:       return {8'h55, "="};
			10:      return {8'h1F, 8'h11}; // Left GUI
			11:      return {8'h27, 8'h12}; // Right GUI
			12:      return {8'h5A, 8'h0A}; // Enter
			13:      return {8'h66, 8'h08}; // Backspace
			14:      return {8'h33, "h"};
			default: return {8'h3E, "8"};
		endcase
	endfunction

	function automatic logic [7:0] lowest_num(input logic [9:0] v);
		for (int i = 0; i < 9; i++)
			if (v[i])
				return 8'h31 + i[7:0];
		return v[9] ? "0" : 8'h00;
	endfunction

	function automatic logic [13:0] cart_addr_exp(input cart_bus_t c);
		if (xrom_exp)
			return {2'b00, c.addr};
		case (size_exp)
			4096:    return {2'b00, c.bank0, c.addr[11], c.addr[9:0]};
			8192:    return {1'b0, c.bank1, c.bank0, c.addr[11], c.addr[9:0]};
			16384:   return {c.bank1, c.bank0, c.addr};
			default: return {3'b000, c.addr[11], c.addr[9:0]};
		endcase
	endfunction

	function automatic logic rden_exp(input cart_bus_t c);
		return xrom_exp ? (~(c.cs_n & c.bank0) & c.rd_n) : ~c.rd_n;
	endfunction

	// Keep the top k bits of one channel, fill below from the other
	function automatic rgb_t shuffle(input rgb_t p, input logic [2:0] contrast);
		logic [7:0] hi;
		logic [7:0] lo;
		int         k;
		rgb_t       s;
		hi = (contrast > 3'd4) ? p.b : p.r;
		lo = (contrast > 3'd4) ? p.r : p.b;
		case (contrast)
			3'd1, 3'd7: k = 7;
			3'd2, 3'd6: k = 6;
			3'd3, 3'd5: k = 4;
			default:    return p;
		endcase
		s.r = (hi & (8'hff << (8 - k))) | (lo >> k);
		s.g = (p.g & (8'hff << k)) | (hi >> (8 - k));
		s.b = s.r;
		return s;
	endfunction

	function automatic logic [7:0] grey_of(input rgb_t c);
		int sum;
		sum = 77 * c.r + 150 * c.g + 29 * c.b;
		return 8'(sum >> 8);
	endfunction

	////////////////////////////////////////////////////////////
	// Directed tests, each entered and left on a falling edge

	task automatic test_enables();
		for (int n = 1; n <= 48; n++) begin
			@(negedge clk_sys);
			check_en(cpu_en_o, (n % 8) == 0, "cpu_en_o ntsc");
			check_en(vdc_en_o, (n % 6) == 0, "vdc_en_o ntsc");
		end
		pal_i = 1'b1;
		@(negedge clk_sys); // Restart edge
		check_en(cpu_en_o, 1'b0, "cpu_en_o restart");
		check_en(vdc_en_o, 1'b0, "vdc_en_o restart");
		for (int m = 1; m <= 60; m++) begin
			@(negedge clk_sys);
			check_en(cpu_en_o, (m % 12) == 0, "cpu_en_o pal");
			check_en(vdc_en_o, (m % 10) == 0, "vdc_en_o pal");
		end
		pal_i = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic send_ps2(input logic [7:0] code, input logic [7:0] ascii);
		key_event_t exp;
		ps2_key_i.toggle   = ~ps2_key_i.toggle;
		ps2_key_i.pressed  = 1'($random(seed));
		ps2_key_i.extended = 1'($random(seed)); // Ignored by the table
		ps2_key_i.code     = code;
		ps2_rel_exp        = ~ps2_key_i.pressed;
		@(negedge clk_sys);
		exp = {1'b1, ps2_rel_exp, ascii};
		check_key(key_o, exp, "key_o ps2 event");
		@(negedge clk_sys);
		exp = {1'b0, ps2_rel_exp, joy_ascii_exp};
		check_key(key_o, exp, "key_o ps2 idle");
	endtask

	task automatic test_ps2();
		logic [15:0] entry;
		for (int i = 0; i < 10; i++) begin
			entry = key_entry({$random(seed)} % 16);
			send_ps2(entry[15:8], entry[7:0]);
		end
		send_ps2(8'h05, 8'h00); // F1, not in the table
		ps2_key_i.pressed = 1'b0; // Key up with no event
		ps2_rel_exp       = 1'b1;
		@(negedge clk_sys);
	endtask

	task automatic test_joy();
		key_event_t exp;
		logic [9:0] v;
		logic [9:0] nv;
		v = 10'd0;
		for (int i = 0; i < 6; i++) begin
			nv = 10'($random(seed));
			while (nv == 10'd0 || nv == v)
				nv = 10'($random(seed));
			v             = nv;
			joy_num_i     = v;
			joy_ascii_exp = lowest_num(v);
			@(negedge clk_sys);
			exp = {1'b1, 1'b0, joy_ascii_exp};
			check_key(key_o, exp, "key_o joy event");
			@(negedge clk_sys);
			exp.valid = 1'b0;
			check_key(key_o, exp, "key_o joy held");
		end
		joy_num_i = 10'd0;
		@(negedge clk_sys);
		exp = {1'b1, 1'b1, joy_ascii_exp};
		check_key(key_o, exp, "key_o joy release");
		@(negedge clk_sys);
		exp.valid = 1'b0;
		check_key(key_o, exp, "key_o joy idle");
	endtask

	task automatic download(input logic [7:0] index, input int bytes);
		rom_port_t  rexp;
		font_port_t fexp;
		ioctl_i.download = 1'b1;
		ioctl_i.index    = index;
		@(negedge clk_sys); // Start seen, count cleared
		xrom_exp = (index[1:0] == IDX_XROM);
		size_exp = 0;
		for (int i = 0; i < bytes; i++) begin
			ioctl_i.wr   = 1'b1;
			ioctl_i.addr = 25'(i);
			ioctl_i.data = 8'($random(seed));
			#1;
			if (index[1:0] == IDX_FONT) begin
				fexp = {ioctl_i.addr[8:0], ioctl_i.data, 1'b1, char_en_i};
				check_font(font_o, fexp, "font_o write");
			end else begin
				rexp = {ioctl_i.addr[13:0], ioctl_i.data, 1'b1, rden_exp(cart_i)};
				check_rom(rom_o, rexp, "rom_o write");
			end
			@(negedge clk_sys);
		end
		size_exp         = bytes;
		ioctl_i.wr       = 1'b0;
		ioctl_i.download = 1'b0;
		@(negedge clk_sys);
	endtask

	task automatic check_mapping(input int samples);
		rom_port_t rexp;
		for (int i = 0; i < samples; i++) begin
			cart_i = 16'($random(seed));
			#1;
			rexp = {cart_addr_exp(cart_i), ioctl_i.data, 1'b0, rden_exp(cart_i)};
			check_rom(rom_o, rexp, "rom_o cart read");
			@(negedge clk_sys);
		end
	endtask

	task automatic test_cart();
		download(8'h01, 4096);
		check_mapping(8);
		download(8'h01, 8192);
		check_mapping(8);
		download(8'h01, 16384);
		check_mapping(8);
		download(8'h01, DL_ODD);
		check_mapping(8);
		download(8'h02, DL_XROM); // XROM mapping and rden
		check_mapping(8);
	endtask

	task automatic test_font();
		font_port_t fexp;
		download(8'h03, DL_FONT);
		for (int i = 0; i < 8; i++) begin
			char_addr_i = 9'($random(seed));
			char_en_i   = 1'($random(seed));
			#1;
			fexp = {char_addr_i, ioctl_i.data, 1'b0, char_en_i};
			check_font(font_o, fexp, "font_o char read");
			@(negedge clk_sys);
		end
	endtask

	task automatic show_pixel(input logic [3:0] code, input logic [2:0] contrast);
		rgb_t       p;
		logic [7:0] g;
		video_out_t exp;
		pix_code_i = code;
		contrast_i = contrast;
		while (!vdc_en_o)
			@(negedge clk_sys); // Next rising edge loads the pixel
		@(negedge clk_sys);
		p = PALETTE[code];
		g = grey_of(shuffle(p, contrast));
		if (contrast == 3'd0)
			exp = {p.r[7:2], p.g[7:2], p.b[7:2], g};
		else
			exp = {g[7:2], g[7:2], g[7:2], g};
		check_video(video_o, exp, "video_o");
	endtask

	task automatic test_colour();
		for (int c = 0; c < 16; c++)
			show_pixel(4'(c), 3'd0);
		for (int i = 0; i < 12; i++)
			show_pixel(4'($random(seed)), 3'({$random(seed)} % 7 + 1));
	endtask

	////////////////////////////////////////////////////////////
	initial begin
		reset       = 1'b1;
		pal_i       = 1'b0;
		contrast_i  = 3'd0;
		ps2_key_i   = '0;
		joy_num_i   = 10'd0;
		ioctl_i     = '0;
		cart_i      = '0;
		char_addr_i = 9'd0;
		char_en_i   = 1'b0;
		pix_code_i  = 4'd0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;

		test_enables();
		test_ps2();
		test_joy();
		test_cart();
		test_font();
		test_colour();

		$display("Errors: key %0d rom %0d font %0d video %0d enable %0d",
			err_key, err_rom, err_font, err_video, err_en);
		if (err_key + err_rom + err_font + err_video + err_en == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: vp_glue.f
+incdir+include
design/vp_glue_pkg.sv
design/vp_clock_enables.sv
design/vp_key_encoder.sv
design/vp_cart_mapper.sv
design/vp_video_color.sv
design/vp_glue.sv
tb/tb_vp_glue.sv
